// File: common/ipod_pkg.sv
package ipod_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int PERIOD_W     = 16;

  // ==================================================
  // Default timing at 50 MHz
  // ==================================================
  // About 11 kHz sample rate
  localparam int DEFAULT_PERIOD   = 4545;
  localparam int PERIOD_STEP      = 100;
  localparam int PERIOD_MIN       = 1000;
  localparam int PERIOD_MAX       = 20000;
  // Last word of the song
  localparam int DEFAULT_END_ADDR = 'h7FFFF;

  // Keyboard command bytes, plain ASCII
  typedef enum logic [7:0] {
    CMD_PLAY     = "E",
    CMD_PAUSE    = "D",
    CMD_FORWARD  = "F",
    CMD_BACKWARD = "B",
    CMD_RESTART  = "R"
  } cmd_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_FETCH,
    SEQ_READY
  } seq_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_READ,
    RD_WAIT_DATA
  } rd_state_e;

endpackage

// File: common/word_fetch_if.sv
interface word_fetch_if;

  // Request side
  logic                              fetch;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] word_addr;

  // Response side, word_data valid with word_done
  logic [ipod_pkg::FLASH_DATA_W-1:0] word_data;
  logic                              word_done;

  modport requester (
    output fetch,
    output word_addr,
    input  word_data,
    input  word_done
  );

  modport server (
    input  fetch,
    input  word_addr,
    output word_data,
    output word_done
  );

endinterface

// File: hw/control/kbd_command_decoder.sv
module kbd_command_decoder (
  input  logic       CLK_50M,
  input  logic       rst_n,
  input  logic [7:0] kbd_ascii,
  input  logic       kbd_valid,
  output logic       play_en,
  output logic       dir_fwd,
  output logic       restart
);

  // Paused and forward out of reset
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      play_en <= 1'b0;
      dir_fwd <= 1'b1;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (kbd_valid)
      begin
        case (kbd_ascii)
          ipod_pkg::CMD_PLAY:
          begin
            play_en <= 1'b1;
          end
          ipod_pkg::CMD_PAUSE:
          begin
            play_en <= 1'b0;
          end
          ipod_pkg::CMD_FORWARD:
          begin
            dir_fwd <= 1'b1;
          end
          ipod_pkg::CMD_BACKWARD:
          begin
            dir_fwd <= 1'b0;
          end
          ipod_pkg::CMD_RESTART:
          begin
            restart <= 1'b1;
          end
          // Other keys are ignored
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

// File: hw/control/sample_rate_ctrl.sv
module sample_rate_ctrl #(
  parameter int DEFAULT_PERIOD = ipod_pkg::DEFAULT_PERIOD,
  parameter int PERIOD_STEP    = ipod_pkg::PERIOD_STEP,
  parameter int PERIOD_MIN     = ipod_pkg::PERIOD_MIN,
  parameter int PERIOD_MAX     = ipod_pkg::PERIOD_MAX
) (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  logic                          btn_faster,
  input  logic                          btn_slower,
  input  logic                          btn_speed_reset,
  output logic [ipod_pkg::PERIOD_W-1:0] sample_period,
  output logic                          sample_tick
);

  typedef logic [ipod_pkg::PERIOD_W-1:0] period_t;

  localparam period_t P_DEFAULT = period_t'(DEFAULT_PERIOD);
  localparam period_t P_STEP    = period_t'(PERIOD_STEP);
  localparam period_t P_MIN     = period_t'(PERIOD_MIN);
  localparam period_t P_MAX     = period_t'(PERIOD_MAX);

  period_t tick_cnt;

  // ==================================================
  // Period register
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      sample_period <= P_DEFAULT;
    end
    else if (btn_speed_reset)
    begin
      sample_period <= P_DEFAULT;
    end
    else if (btn_faster)
    begin
      // Shorter period, clamped at the minimum
      if (sample_period < P_MIN + P_STEP)
        sample_period <= P_MIN;
      else
        sample_period <= sample_period - P_STEP;
    end
    else if (btn_slower)
    begin
      if (sample_period > P_MAX - P_STEP)
        sample_period <= P_MAX;
      else
        sample_period <= sample_period + P_STEP;
    end
  end

  // ==================================================
  // Tick divider
  // ==================================================
  // Reload picks up the period current at that moment
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      tick_cnt <= P_DEFAULT - 1'b1;
    else if (tick_cnt == '0)
      tick_cnt <= sample_period - 1'b1;
    else
      tick_cnt <= tick_cnt - 1'b1;
  end

  assign sample_tick = (tick_cnt == '0);

endmodule

// File: hw/ipod_top.sv
module ipod_top #(
  parameter int DEFAULT_PERIOD = ipod_pkg::DEFAULT_PERIOD,
  parameter int PERIOD_STEP    = ipod_pkg::PERIOD_STEP,
  parameter int PERIOD_MIN     = ipod_pkg::PERIOD_MIN,
  parameter int PERIOD_MAX     = ipod_pkg::PERIOD_MAX,
  parameter int END_ADDR       = ipod_pkg::DEFAULT_END_ADDR
) (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  input  logic [7:0]                        kbd_ascii,
  input  logic                              kbd_valid,
  input  logic                              btn_faster,
  input  logic                              btn_slower,
  input  logic                              btn_speed_reset,
  output logic                              flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                              flash_readdatavalid,
  output logic [ipod_pkg::SAMPLE_W-1:0]     audio_sample,
  output logic                              sample_valid,
  output logic [ipod_pkg::PERIOD_W-1:0]     sample_period,
  output logic                              playing,
  output logic                              forward
);

  logic restart;
  logic sample_tick;

  word_fetch_if fetch_bus ();

  // ==================================================
  // Control
  // ==================================================
  kbd_command_decoder kbd_command_decoder_i (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_valid (kbd_valid),
    .play_en   (playing),
    .dir_fwd   (forward),
    .restart   (restart)
  );

  sample_rate_ctrl #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .PERIOD_MIN     (PERIOD_MIN),
    .PERIOD_MAX     (PERIOD_MAX)
  ) sample_rate_ctrl_i (
    .CLK_50M         (CLK_50M),
    .rst_n           (rst_n),
    .btn_faster      (btn_faster),
    .btn_slower      (btn_slower),
    .btn_speed_reset (btn_speed_reset),
    .sample_period   (sample_period),
    .sample_tick     (sample_tick)
  );

  // ==================================================
  // Playback
  // ==================================================
  playback_sequencer #(
    .END_ADDR (END_ADDR)
  ) playback_sequencer_i (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .play_en      (playing),
    .dir_fwd      (forward),
    .restart      (restart),
    .sample_tick  (sample_tick),
    .fetch        (fetch_bus.requester),
    .audio_sample (audio_sample),
    .sample_valid (sample_valid)
  );

  flash_reader flash_reader_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .fetch               (fetch_bus.server),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

endmodule

// File: hw/playback/flash_reader.sv
module flash_reader (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  word_fetch_if.server                      fetch,
  output logic                              flash_read,
  output logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address,
  input  logic                              flash_waitrequest,
  input  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata,
  input  logic                              flash_readdatavalid
);

  ipod_pkg::rd_state_e state;

  // ==================================================
  // Read handshake
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state           <= ipod_pkg::RD_IDLE;
      flash_read      <= 1'b0;
      fetch.word_done <= 1'b0;
    end
    else
    begin
      fetch.word_done <= 1'b0;
      case (state)
        ipod_pkg::RD_IDLE:
        begin
          if (fetch.fetch)
          begin
            flash_read <= 1'b1;
            state      <= ipod_pkg::RD_READ;
          end
        end
        // Address and read held while the flash stalls
        ipod_pkg::RD_READ:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ipod_pkg::RD_WAIT_DATA;
          end
        end
        ipod_pkg::RD_WAIT_DATA:
        begin
          if (flash_readdatavalid)
          begin
            fetch.word_done <= 1'b1;
            state           <= ipod_pkg::RD_IDLE;
          end
        end
        default:
        begin
          state <= ipod_pkg::RD_IDLE;
        end
      endcase
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (state == ipod_pkg::RD_IDLE && fetch.fetch)
      flash_address <= fetch.word_addr;
    if (state == ipod_pkg::RD_WAIT_DATA && flash_readdatavalid)
      fetch.word_data <= flash_readdata;
  end

endmodule

// File: hw/playback/playback_sequencer.sv
module playback_sequencer #(
  parameter int END_ADDR = ipod_pkg::DEFAULT_END_ADDR
) (
  input  logic                          CLK_50M,
  input  logic                          rst_n,
  input  logic                          play_en,
  input  logic                          dir_fwd,
  input  logic                          restart,
  input  logic                          sample_tick,
  word_fetch_if.requester               fetch,
  output logic [ipod_pkg::SAMPLE_W-1:0] audio_sample,
  output logic                          sample_valid
);

  // Two samples per flash word
  localparam int LAST_IDX = 2 * END_ADDR + 1;
  localparam int IDX_W    = $clog2(LAST_IDX + 1);
  localparam int DATA_W   = ipod_pkg::FLASH_DATA_W;

  typedef logic [IDX_W-1:0] idx_t;

  ipod_pkg::seq_state_e state;
  idx_t                 idx;
  idx_t                 idx_next;
  idx_t                 idx_flip;
  logic [DATA_W-1:0]    word_q;
  logic                 dir_q;
  logic                 tick_pend;
  logic                 refetch;
  logic                 emit;

  function automatic idx_t step(input idx_t i, input logic up);
    if (up)
      return (i == idx_t'(LAST_IDX)) ? '0 : i + 1'b1;
    else
      return (i == '0) ? idx_t'(LAST_IDX) : i - 1'b1;
  endfunction

  assign idx_next = step(idx, dir_q);
  // Direction change resumes next to the last played sample
  assign idx_flip = step(step(idx, dir_fwd), dir_fwd);

  assign emit = (state == ipod_pkg::SEQ_READY) && play_en && !restart &&
                (dir_fwd == dir_q) && (sample_tick || tick_pend);

  assign fetch.word_addr = ipod_pkg::FLASH_ADDR_W'(idx >> 1);

  // ==================================================
  // Control FSM
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state        <= ipod_pkg::SEQ_IDLE;
      idx          <= '0;
      dir_q        <= 1'b1;
      tick_pend    <= 1'b0;
      refetch      <= 1'b0;
      fetch.fetch  <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      fetch.fetch  <= 1'b0;
      sample_valid <= emit;

      // Hold a tick until the word is loaded
      if (!play_en || restart || emit)
        tick_pend <= 1'b0;
      else if (sample_tick)
        tick_pend <= 1'b1;

      if (restart)
      begin
        idx   <= dir_fwd ? '0 : idx_t'(LAST_IDX);
        dir_q <= dir_fwd;
        // A read in flight is dropped when it returns
        if (state == ipod_pkg::SEQ_FETCH && !fetch.word_done)
        begin
          refetch <= 1'b1;
        end
        else
        begin
          refetch <= 1'b0;
          state   <= ipod_pkg::SEQ_IDLE;
        end
      end
      else
      begin
        case (state)
          ipod_pkg::SEQ_IDLE:
          begin
            fetch.fetch <= 1'b1;
            state       <= ipod_pkg::SEQ_FETCH;
          end
          ipod_pkg::SEQ_FETCH:
          begin
            if (fetch.word_done)
            begin
              refetch <= 1'b0;
              state   <= refetch ? ipod_pkg::SEQ_IDLE : ipod_pkg::SEQ_READY;
            end
          end
          ipod_pkg::SEQ_READY:
          begin
            if (dir_fwd != dir_q)
            begin
              idx   <= idx_flip;
              dir_q <= dir_fwd;
              if ((idx_flip >> 1) != (idx >> 1))
                state <= ipod_pkg::SEQ_IDLE;
            end
            else if (emit)
            begin
              idx <= idx_next;
              if ((idx_next >> 1) != (idx >> 1))
                state <= ipod_pkg::SEQ_IDLE;
            end
          end
          default:
          begin
            state <= ipod_pkg::SEQ_IDLE;
          end
        endcase
      end
    end
  end

  // ==================================================
  // Word and sample data
  // ==================================================
  always_ff @(posedge CLK_50M)
  begin
    if (state == ipod_pkg::SEQ_FETCH && fetch.word_done)
      word_q <= fetch.word_data;
    // Upper byte of the selected 16-bit half
    if (emit)
      audio_sample <= idx[0] ? word_q[DATA_W-1 -: ipod_pkg::SAMPLE_W]
                             : word_q[DATA_W/2-1 -: ipod_pkg::SAMPLE_W];
  end

endmodule

// File: project.f
common/ipod_pkg.sv
common/word_fetch_if.sv
hw/control/kbd_command_decoder.sv
hw/control/sample_rate_ctrl.sv
hw/playback/playback_sequencer.sv
hw/playback/flash_reader.sv
hw/ipod_top.sv
verif/flash_model.sv
verif/tb_ipod_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ipod_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb_ipod_top

verilator --binary --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_ipod_top -f project.f -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0

// File: verif/flash_model.sv
module flash_model (
  input  logic                              CLK_50M,
  input  logic                              rst_n,
  input  logic                              read,
  input  logic [ipod_pkg::FLASH_ADDR_W-1:0] address,
  output logic                              waitrequest,
  output logic [ipod_pkg::FLASH_DATA_W-1:0] readdata,
  output logic                              readdatavalid
);
  timeunit 1ns;
  timeprecision 100ps;

  integer                            seed;
  int                                wait_left;
  int                                lat_left;
  logic                              busy;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] addr_q;

  initial seed = 32'h90907bd0;

  // Upper bytes of the halves hold 2a and 2a+1, the rest is address noise
  function automatic logic [31:0] word_at(input logic [ipod_pkg::FLASH_ADDR_W-1:0] a);
    logic [7:0] noise;
    noise = a[7:0] ^ a[15:8] ^ {1'b0, a[22:16]};
    return {{a[6:0], 1'b1}, noise ^ 8'h3C, {a[6:0], 1'b0}, noise ^ 8'hC3};
  endfunction

  // Stall counter loaded ahead of each read
  assign waitrequest = (wait_left != 0);

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      wait_left     <= 0;
      lat_left      <= 0;
      busy          <= 1'b0;
      readdatavalid <= 1'b0;
    end
    else
    begin
      readdatavalid <= 1'b0;
      if (read && wait_left != 0)
      begin
        wait_left <= wait_left - 1;
      end
      else if (read)
      begin
        // Accepted, data follows 2 to 4 cycles later
        addr_q    <= address;
        busy      <= 1'b1;
        lat_left  <= 1 + ($unsigned($random(seed)) % 3);
        wait_left <= $unsigned($random(seed)) % 3;
      end
      if (busy)
      begin
        if (lat_left == 0)
        begin
          readdatavalid <= 1'b1;
          readdata      <= word_at(addr_q);
          busy          <= 1'b0;
        end
        else
        begin
          lat_left <= lat_left - 1;
        end
      end
    end
  end

endmodule

// File: verif/tb_ipod_top.sv
module tb_ipod_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD_DEF = 40;
  localparam int STEP       = 8;
  localparam int P_MIN      = 24;
  localparam int P_MAX      = 56;
  localparam int END_ADDR   = 7;
  // Two samples per flash word
  localparam int LAST_IDX   = 2 * (END_ADDR + 1) - 1;
  // About three times the stimulus length
  localparam int MAX_CYCLES = 6000;

  localparam int BTN_FASTER = 0;
  localparam int BTN_SLOWER = 1;
  localparam int BTN_RESET  = 2;

  logic                              CLK_50M = 1'b0;
  logic                              rst_n;
  logic [7:0]                        kbd_ascii;
  logic                              kbd_valid;
  logic                              btn_faster;
  logic                              btn_slower;
  logic                              btn_speed_reset;
  logic                              flash_read;
  logic [ipod_pkg::FLASH_ADDR_W-1:0] flash_address;
  logic                              flash_waitrequest;
  logic [ipod_pkg::FLASH_DATA_W-1:0] flash_readdata;
  logic                              flash_readdatavalid;
  logic [ipod_pkg::SAMPLE_W-1:0]     audio_sample;
  logic                              sample_valid;
  logic [ipod_pkg::PERIOD_W-1:0]     sample_period;
  logic                              playing;
  logic                              forward;

  // Reference index and timing model
  int cycle      = 0;
  int last_idx   = -1;
  int forced_idx = -1;
  int exp_idx    = 0;
  int last_cycle = 0;
  int gap_period = 0;
  bit gap_valid  = 1'b0;
  int exp_period = PERIOD_DEF;
  bit exp_play   = 1'b0;
  bit exp_fwd    = 1'b1;

  always #10 CLK_50M = ~CLK_50M;

  ipod_top #(
    .DEFAULT_PERIOD (PERIOD_DEF),
    .PERIOD_STEP    (STEP),
    .PERIOD_MIN     (P_MIN),
    .PERIOD_MAX     (P_MAX),
    .END_ADDR       (END_ADDR)
  ) ipod_top_i (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .kbd_ascii           (kbd_ascii),
    .kbd_valid           (kbd_valid),
    .btn_faster          (btn_faster),
    .btn_slower          (btn_slower),
    .btn_speed_reset     (btn_speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .sample_period       (sample_period),
    .playing             (playing),
    .forward             (forward)
  );

  flash_model flash_model_i (
    .CLK_50M       (CLK_50M),
    .rst_n         (rst_n),
    .read          (flash_read),
    .address       (flash_address),
    .waitrequest   (flash_waitrequest),
    .readdata      (flash_readdata),
    .readdatavalid (flash_readdatavalid)
  );

  task automatic report_failure(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run stopped at the first failed check");
  endtask

  // Index step with wrap at both ends of the song
  function automatic int wrap_step(input int i, input bit up);
    if (up)
      return (i == LAST_IDX) ? 0 : i + 1;
    else
      return (i == 0) ? LAST_IDX : i - 1;
  endfunction

  // ==================================================
  // Assertions
  // ==================================================
  assert property (@(posedge CLK_50M) disable iff (!rst_n) sample_valid |-> $past(playing))
  else report_failure("sample_valid pulsed while paused");

  assert property (@(posedge CLK_50M) disable iff (!rst_n)
                   (flash_read && flash_waitrequest) |=>
                   (flash_read && $stable(flash_address)))
  else report_failure("flash request changed under waitrequest");

  // Sample values and spacing, plus the run limit
  always @(posedge CLK_50M)
  begin
    cycle = cycle + 1;
    if (cycle >= MAX_CYCLES)
    begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
    if (rst_n && sample_valid)
    begin
      if (forced_idx >= 0)
        exp_idx = forced_idx;
      else if (last_idx < 0)
        exp_idx = 0;
      else
        exp_idx = wrap_step(last_idx, exp_fwd);
      assert (audio_sample == exp_idx[7:0])
      else report_failure($sformatf("audio_sample %0d, expected %0d", audio_sample, exp_idx));
      if (gap_valid)
      begin
        assert (cycle - last_cycle == gap_period)
        else report_failure($sformatf("sample spacing %0d, expected %0d",
                                      cycle - last_cycle, gap_period));
      end
      last_idx   = exp_idx;
      forced_idx = -1;
      last_cycle = cycle;
      gap_period = exp_period;
      gap_valid  = 1'b1;
    end
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic wait_sample();
    @(posedge CLK_50M);
    while (!sample_valid)
      @(posedge CLK_50M);
    @(posedge CLK_50M);
  endtask

  task automatic send_key(input logic [7:0] key);
    kbd_ascii <= key;
    kbd_valid <= 1'b1;
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
    gap_valid = 1'b0;
    case (key)
      "E":
      begin
        exp_play = 1'b1;
      end
      "D":
      begin
        exp_play = 1'b0;
      end
      "F":
      begin
        exp_fwd = 1'b1;
      end
      "B":
      begin
        exp_fwd = 1'b0;
      end
      // Restart target follows the current direction
      "R":
      begin
        forced_idx = exp_fwd ? 0 : LAST_IDX;
      end
      default:
      begin
      end
    endcase
    @(posedge CLK_50M);
    assert (playing == exp_play && forward == exp_fwd)
    else report_failure($sformatf("playing %0b forward %0b, expected %0b %0b",
                                  playing, forward, exp_play, exp_fwd));
  endtask

  task automatic press_speed_button(input int which);
    case (which)
      BTN_FASTER:
      begin
        btn_faster <= 1'b1;
        exp_period = (exp_period - STEP < P_MIN) ? P_MIN : exp_period - STEP;
      end
      BTN_SLOWER:
      begin
        btn_slower <= 1'b1;
        exp_period = (exp_period + STEP > P_MAX) ? P_MAX : exp_period + STEP;
      end
      default:
      begin
        btn_speed_reset <= 1'b1;
        exp_period = PERIOD_DEF;
      end
    endcase
    @(posedge CLK_50M);
    btn_faster      <= 1'b0;
    btn_slower      <= 1'b0;
    btn_speed_reset <= 1'b0;
    @(posedge CLK_50M);
    assert (int'(sample_period) == exp_period)
    else report_failure($sformatf("sample_period %0d, expected %0d", sample_period, exp_period));
  endtask

  initial
  begin
    rst_n           <= 1'b0;
    kbd_ascii       <= 8'h00;
    kbd_valid       <= 1'b0;
    btn_faster      <= 1'b0;
    btn_slower      <= 1'b0;
    btn_speed_reset <= 1'b0;
    repeat (16) @(posedge CLK_50M);
    rst_n <= 1'b1;
    repeat (2) @(posedge CLK_50M);
    assert (!playing && forward && int'(sample_period) == PERIOD_DEF)
    else report_failure("wrong state after reset");
    repeat (3 * PERIOD_DEF) @(posedge CLK_50M);

    // Forward through the whole song and wrap
    send_key("E");
    repeat (17) wait_sample();
    send_key("B");
    repeat (5) wait_sample();
    send_key("F");
    repeat (3) wait_sample();

    // Pause and resume
    send_key("D");
    repeat (3 * PERIOD_DEF) @(posedge CLK_50M);
    assert (!playing)
    else report_failure("playing still set after pause");
    send_key("E");
    repeat (3) wait_sample();

    // Speed steps with clamping
    repeat (4)
    begin
      press_speed_button(BTN_FASTER);
      wait_sample();
    end
    repeat (5)
    begin
      press_speed_button(BTN_SLOWER);
      wait_sample();
    end
    press_speed_button(BTN_RESET);
    repeat (2) wait_sample();

    // Restart in both directions
    send_key("R");
    repeat (2) wait_sample();
    send_key("B");
    repeat (2) wait_sample();
    send_key("R");
    repeat (2) wait_sample();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
